/* Makefile */
# Verilator simulation of the ROM download path
# Example: make sim HALF_GAP=8

VERILATOR ?= verilator
TOP       ?= tb_rom_download
FILELIST  ?= rom_download.f
HALF_GAP  ?= 24
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) -GHALF_GAP=$(HALF_GAP) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rom_download.f */
src/dl_pkg.sv
src/dl_word_splitter.sv
src/dl_index_router.sv
src/rom_download.sv
tb/rom_download_properties.sv
tb/tb_rom_download.sv

/* src/dl_index_router.sv */
/* Sends each downloaded byte to its target by download index: the ROM
   write port, the DIP switch bank or the core-mode register */

`timescale 1ns/1ps

module dl_index_router (
    input  logic              clk_rom,
    input  logic              rst,
    // Session state from the host
    input  logic              dl_active,
    input  dl_pkg::index_t    dl_index,
    // Byte writes from the splitter
    input  logic              byte_wr,
    input  dl_pkg::addr_t     byte_addr,
    input  dl_pkg::byte_t     byte_data,
    // ROM writer port, one cycle behind byte_wr
    output logic              rom_wr,
    output dl_pkg::addr_t     rom_addr,
    output dl_pkg::byte_t     rom_data,
    // Configuration registers
    output dl_pkg::dipsw_t    dipsw,
    output dl_pkg::core_mod_t core_mod,
    output logic              downloading
);
    import dl_pkg::*;

    localparam int DIP_SEL_W = $clog2(DIP_BYTES);
    localparam int CORE_W    = $bits(core_mod_t);

    logic                 is_rom;
    logic                 is_dip;
    logic                 is_core;
    logic                 dip_hit;      // Address falls inside the DIP bank
    logic [DIP_SEL_W-1:0] dip_sel;
    logic                 rom_sel;
    logic                 dip_sel_wr;
    logic                 core_sel_wr;

    // Index decode, shared by all targets
    assign is_rom  = (dl_index == IDX_ROM);
    assign is_dip  = (dl_index == IDX_DIP);
    assign is_core = (dl_index == IDX_CORE_MOD);

    assign dip_hit = (byte_addr < ADDR_W'(DIP_BYTES));
    assign dip_sel = byte_addr[DIP_SEL_W-1:0];

    assign rom_sel     = byte_wr && is_rom;
    assign dip_sel_wr  = byte_wr && is_dip && dip_hit;
    // Odd byte of a word would clobber the value just written
    assign core_sel_wr = byte_wr && is_core && !byte_addr[0];

    // Tells the rest of the board a ROM load is running
    assign downloading = dl_active && is_rom;

    // ROM write strobe
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            rom_wr <= 1'b0;
        end else begin
            rom_wr <= rom_sel;
        end
    end

    // ROM address and data follow the strobe
    always_ff @(posedge clk_rom) begin
        if (rom_sel) begin
            rom_addr <= byte_addr;
            rom_data <= byte_data;
        end
    end

    // DIP bank, one byte per address
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            dipsw <= DIPSW_RESET;
        end else if (dip_sel_wr) begin
            dipsw[{dip_sel, 3'b000} +: 8] <= byte_data;
        end
    end

    // Core mode flags
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            core_mod <= CORE_MOD_RESET;
        end else if (core_sel_wr) begin
            core_mod <= byte_data[CORE_W-1:0];  // Bit 7 unused
        end
    end

endmodule

/* src/dl_pkg.sv */
/* Download types, target index codes and reset values shared by the ROM
   download path. Modules import it inside their body. */

package dl_pkg;

    localparam int ADDR_W    = 25;  // Byte address width from the host
    localparam int DIP_BYTES = 4;

    typedef logic [7:0]             byte_t;
    typedef logic [15:0]            word_t;
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [7:0]             index_t;

    // Byte 0 of the DIP bank sits in the low bits
    typedef logic [8*DIP_BYTES-1:0] dipsw_t;

    typedef logic [6:0]             core_mod_t;

    // Download index codes sent by the host
    localparam index_t IDX_ROM      = 8'd0;
    localparam index_t IDX_CORE_MOD = 8'd1;
    localparam index_t IDX_DIP      = 8'd254;

    // Register values after reset
    localparam core_mod_t CORE_MOD_RESET = 7'd1;
    localparam dipsw_t    DIPSW_RESET    = '1;   // All switches off

endpackage

/* src/dl_word_splitter.sv */
/* Takes one 16-bit download word per four-phase req/ack transfer and
   issues it as two byte writes, low byte first, HALF_GAP cycles apart */

`timescale 1ns/1ps

module dl_word_splitter #(
    parameter int HALF_GAP = 24     // Cycles from first to second byte write
) (
    input  logic          clk_rom,
    input  logic          rst,
    // Host side
    input  logic          dl_req,
    input  dl_pkg::addr_t dl_addr,
    input  dl_pkg::word_t dl_data,
    output logic          dl_ack,
    // Byte write strobe towards the router
    output logic          byte_wr,
    output dl_pkg::addr_t byte_addr,
    output dl_pkg::byte_t byte_data
);
    import dl_pkg::*;

    localparam int              CNT_W    = $clog2(HALF_GAP);
    localparam logic [CNT_W-1:0] GAP_LOAD = CNT_W'(HALF_GAP - 1);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for dl_req
        ST_GAP,     // Low byte sent, counting down
        ST_HIGH,    // High byte strobe on the bus
        ST_ACK      // dl_ack high until dl_req drops
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] gap_cnt;
    byte_t            word_hi;      // High byte held for the second write
    logic             accept;
    logic             emit_hi;

    // The gap counter needs at least one idle cycle between strobes
    if (HALF_GAP < 2) begin : g_gap_check
        $error("HALF_GAP must be at least 2");
    end

    assign accept  = (state == ST_IDLE) && dl_req;
    assign emit_hi = (state == ST_GAP) && (gap_cnt == '0);

    // Handshake and strobe sequencing
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            gap_cnt <= '0;
            byte_wr <= 1'b0;
            dl_ack  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        byte_wr <= 1'b1;        // Low byte goes out next cycle
                        gap_cnt <= GAP_LOAD;
                        state   <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    if (emit_hi) begin
                        byte_wr <= 1'b1;
                        state   <= ST_HIGH;
                    end else begin
                        byte_wr <= 1'b0;
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                ST_HIGH: begin
                    byte_wr <= 1'b0;
                    dl_ack  <= 1'b1;            // Both bytes are out
                    state   <= ST_ACK;
                end
                ST_ACK: begin
                    // Host releases the request, return to idle
                    if (!dl_req) begin
                        dl_ack <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Byte payload, only meaningful while byte_wr is high
    always_ff @(posedge clk_rom) begin
        if (accept) begin
            byte_addr <= {dl_addr[ADDR_W-1:1], 1'b0};  // Words start even
            byte_data <= dl_data[7:0];
            word_hi   <= dl_data[15:8];
        end else if (emit_hi) begin
            byte_addr[0] <= 1'b1;
            byte_data    <= word_hi;
        end
    end

endmodule

/* src/rom_download.sv */
/* ROM download path top level. Host words enter through the splitter and
   the resulting bytes are routed to the ROM port and config registers. */

`timescale 1ns/1ps

module rom_download #(
    parameter int HALF_GAP = 24     // Spacing of the two byte writes per word
) (
    input  logic              clk_rom,
    input  logic              rst,
    // Host download interface, four-phase req/ack
    input  logic              dl_req,
    output logic              dl_ack,
    input  dl_pkg::addr_t     dl_addr,
    input  dl_pkg::word_t     dl_data,
    input  dl_pkg::index_t    dl_index,
    input  logic              dl_active,    // High for the whole session
    // ROM writer
    output logic              rom_wr,
    output dl_pkg::addr_t     rom_addr,
    output dl_pkg::byte_t     rom_data,
    // Configuration outputs
    output dl_pkg::dipsw_t    dipsw,
    output dl_pkg::core_mod_t core_mod,
    output logic              downloading
);
    import dl_pkg::*;

    // Byte stream between splitter and router
    logic  byte_wr;
    addr_t byte_addr;
    byte_t byte_data;

    dl_word_splitter #(
        .HALF_GAP  ( HALF_GAP  )
    ) u_splitter (
        .clk_rom   ( clk_rom   ),
        .rst       ( rst       ),
        .dl_req    ( dl_req    ),
        .dl_addr   ( dl_addr   ),
        .dl_data   ( dl_data   ),
        .dl_ack    ( dl_ack    ),
        .byte_wr   ( byte_wr   ),
        .byte_addr ( byte_addr ),
        .byte_data ( byte_data )
    );

    // Router adds one register stage on the ROM side
    dl_index_router u_router (
        .clk_rom     ( clk_rom     ),
        .rst         ( rst         ),
        .dl_active   ( dl_active   ),
        .dl_index    ( dl_index    ),
        .byte_wr     ( byte_wr     ),
        .byte_addr   ( byte_addr   ),
        .byte_data   ( byte_data   ),
        .rom_wr      ( rom_wr      ),
        .rom_addr    ( rom_addr    ),
        .rom_data    ( rom_data    ),
        .dipsw       ( dipsw       ),
        .core_mod    ( core_mod    ),
        .downloading ( downloading )
    );

endmodule

/* tb/rom_download_properties.sv */
/* Concurrent checks on the host handshake and the ROM write strobe,
   bound into the rom_download top level */

`timescale 1ns/1ps

module rom_download_properties (
    input logic clk_rom,
    input logic rst,
    input logic dl_req,
    input logic dl_ack,
    input logic rom_wr
);

    // Ack may only come up while the host still requests
    ack_rise_with_req: assert property (@(posedge clk_rom) disable iff (rst)
        $rose(dl_ack) |-> dl_req)
        else $error("dl_ack rose while dl_req was low");

    ack_fall_after_req: assert property (@(posedge clk_rom) disable iff (rst)
        $fell(dl_ack) |-> !$past(dl_req))
        else $error("dl_ack fell before dl_req was released");

    rom_wr_single: assert property (@(posedge clk_rom) disable iff (rst)
        rom_wr |=> !rom_wr)
        else $error("rom_wr high on two cycles in a row");

    rom_wr_in_reset: assert property (@(posedge clk_rom) rst |-> !rom_wr)
        else $error("rom_wr high during reset");

endmodule

bind rom_download rom_download_properties i_properties (
    .clk_rom ( clk_rom ),
    .rst     ( rst     ),
    .dl_req  ( dl_req  ),
    .dl_ack  ( dl_ack  ),
    .rom_wr  ( rom_wr  )
);

/* tb/rom_download_vectors.txt */
# One host transfer per line, all fields hex
# index  byte_addr  data  expected_dipsw  expected_core_mod
00 0000000 1234 ffffffff 01
00 0000002 abcd ffffffff 01
00 0000004 00ff ffffffff 01
00 1fffffe 8001 ffffffff 01
00 0123456 c3a5 ffffffff 01
# DIP bank, addresses 4 and up fall outside it
fe 0000000 3c12 ffff3c12 01
fe 0000002 7856 78563c12 01
fe 0000004 ffff 78563c12 01
fe 0000100 0000 78563c12 01
fe 0000000 a5c3 7856a5c3 01
fe 0000002 0f0e 0f0ea5c3 01
# Core mode takes the low 7 bits of the low byte only
01 0000000 ff85 0f0ea5c3 05
01 0000002 007f 0f0ea5c3 7f
01 0000040 8000 0f0ea5c3 00
01 0000006 ff2a 0f0ea5c3 2a
00 0000100 dead 0f0ea5c3 2a
00 0000102 beef 0f0ea5c3 2a
# Unused index, nothing may change
02 0000000 5555 0f0ea5c3 2a
fe 0000006 1234 0f0ea5c3 2a
fe 0000002 ffff ffffa5c3 2a
01 0000008 0133 ffffa5c3 33
00 0000200 0102 ffffa5c3 33
00 0000202 0304 ffffa5c3 33

/* tb/tb_rom_download.sv */
/* Testbench for the ROM download path. Replays host transfers from the
   vector file and checks ROM writes, handshake timing and config registers */

`timescale 1ns/1ps

module tb_rom_download #(
    parameter int HALF_GAP = 24
);
    import dl_pkg::*;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 16;
    localparam string VEC_FILE     = "tb/rom_download_vectors.txt";

    logic        clk_rom;
    logic        rst;
    logic        dl_req;
    logic        dl_ack;
    addr_t       dl_addr;
    word_t       dl_data;
    index_t      dl_index;
    logic        dl_active;
    logic        rom_wr;
    addr_t       rom_addr;
    byte_t       rom_data;
    dipsw_t      dipsw;
    core_mod_t   core_mod;
    logic        downloading;

    // Vector table
    index_t      vec_index[$];
    addr_t       vec_addr[$];
    word_t       vec_data[$];
    dipsw_t      vec_dipsw[$];
    core_mod_t   vec_core[$];

    addr_t       exp_addr_q[$];     // ROM writes still expected
    byte_t       exp_data_q[$];

    int          value_errors = 0;
    int          proto_errors = 0;
    int          cyc = 0;           // Rising edges since start
    int          first_wr_cyc = 0;
    int          second_wr_cyc = 0;
    int          req_fall_cyc = 0;
    int          wr_seen = 0;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;
    logic [31:0] lfsr = 32'h7267_ccd6;
    bit          vectors_loaded = 1'b0;

    rom_download #(
        .HALF_GAP    ( HALF_GAP    )
    ) i_rom_download (
        .clk_rom     ( clk_rom     ),
        .rst         ( rst         ),
        .dl_req      ( dl_req      ),
        .dl_ack      ( dl_ack      ),
        .dl_addr     ( dl_addr     ),
        .dl_data     ( dl_data     ),
        .dl_index    ( dl_index    ),
        .dl_active   ( dl_active   ),
        .rom_wr      ( rom_wr      ),
        .rom_addr    ( rom_addr    ),
        .rom_data    ( rom_data    ),
        .dipsw       ( dipsw       ),
        .core_mod    ( core_mod    ),
        .downloading ( downloading )
    );

    initial begin
        clk_rom = 1'b0;
        forever #(CLK_PERIOD / 2) clk_rom = ~clk_rom;
    end

    always @(posedge clk_rom) cyc <= cyc + 1;

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %07h expected %07h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_dipsw(input string name, input dipsw_t got, input dipsw_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_core_mod(input string name, input core_mod_t got,
                                  input core_mod_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %02h expected %02h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic load_vectors();
        int        fd;
        int        n_fields;
        string     line;
        index_t    idx;
        addr_t     addr;
        word_t     data;
        dipsw_t    dip;
        core_mod_t cm;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open vector file %s", VEC_FILE);
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() == 0 || line[0] == "#") continue;
            n_fields = $sscanf(line, "%h %h %h %h %h", idx, addr, data, dip, cm);
            if (n_fields == 5) begin
                vec_index.push_back(idx);
                vec_addr.push_back(addr);
                vec_data.push_back(data);
                vec_dipsw.push_back(dip);
                vec_core.push_back(cm);
            end
        end
        $fclose(fd);
    endtask

    // Index may only change while no session is open
    task automatic start_session(input index_t idx);
        @(posedge clk_rom);
        dl_active <= 1'b0;
        @(posedge clk_rom);
        dl_index  <= idx;
        @(posedge clk_rom);
        dl_active <= 1'b1;
    endtask

    task automatic run_transfer(input addr_t addr, input word_t data);
        int hold;
        // Low byte at the word address and high byte one above
        if (dl_index == IDX_ROM) begin
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data[7:0]);
            exp_addr_q.push_back(addr + addr_t'(1));
            exp_data_q.push_back(data[15:8]);
        end
        @(posedge clk_rom);
        dl_addr <= addr;
        dl_data <= data;
        dl_req  <= 1'b1;
        @(negedge clk_rom);
        while (!dl_ack) @(negedge clk_rom);
        draw_bits(3, hold);
        repeat (hold) @(posedge clk_rom);
        @(posedge clk_rom);
        dl_req <= 1'b0;
        @(negedge clk_rom);
        while (dl_ack) @(negedge clk_rom);
    endtask

    // Protocol monitor sampling at the falling edge
    always @(negedge clk_rom) begin
        if (!rst) begin
            if (dl_req && !req_prev) begin
                // Next rising edge accepts and rom_wr follows one edge later
                first_wr_cyc  = cyc + 2;
                second_wr_cyc = cyc + 2 + HALF_GAP;
                wr_seen       = 0;
            end
            if (!dl_req && req_prev) req_fall_cyc = cyc;
            if (rom_wr) begin
                if (dl_index != IDX_ROM) begin
                    $display("ERROR at %0t: rom_wr strobe while download index is %02h",
                             $time, dl_index);
                    proto_errors++;
                end else if (exp_addr_q.size() == 0) begin
                    $display("ERROR at %0t: rom_wr strobe with no write expected", $time);
                    proto_errors++;
                end else begin
                    check_cycle("rom_wr cycle", cyc,
                                (wr_seen == 0) ? first_wr_cyc : second_wr_cyc);
                    check_addr("rom_addr", rom_addr, exp_addr_q.pop_front());
                    check_byte("rom_data", rom_data, exp_data_q.pop_front());
                end
                wr_seen++;
            end
            if (dl_ack && !ack_prev) check_cycle("dl_ack rise cycle", cyc, second_wr_cyc);
            if (!dl_ack && ack_prev) check_cycle("dl_ack fall cycle", cyc, req_fall_cyc + 1);
            check_flag("downloading", downloading, dl_active && (dl_index == IDX_ROM));
        end
        req_prev = dl_req;
        ack_prev = dl_ack;
    end

    initial begin
        int gap;
        rst       = 1'b1;
        dl_req    = 1'b0;
        dl_addr   = '0;
        dl_data   = '0;
        dl_index  = IDX_ROM;
        dl_active = 1'b0;
        load_vectors();
        if (vec_index.size() == 0) begin
            $display("ERROR: no transfers read from %s", VEC_FILE);
            proto_errors++;
        end else begin
            vectors_loaded = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk_rom);
            rst <= 1'b0;
            foreach (vec_index[i]) begin
                if (!dl_active || dl_index != vec_index[i]) start_session(vec_index[i]);
                run_transfer(vec_addr[i], vec_data[i]);
                if (exp_addr_q.size() != 0) begin
                    $display("ERROR at %0t: %0d expected rom_wr strobes never came",
                             $time, exp_addr_q.size());
                    proto_errors++;
                    exp_addr_q.delete();
                    exp_data_q.delete();
                end
                check_dipsw("dipsw", dipsw, vec_dipsw[i]);
                check_core_mod("core_mod", core_mod, vec_core[i]);
                draw_bits(3, gap);
                repeat (gap) @(posedge clk_rom);   // Idle time between transfers
            end
            @(posedge clk_rom);
            dl_active <= 1'b0;
            repeat (2) @(negedge clk_rom);
        end
        $display("Done: %0d transfers, %0d value errors, %0d protocol errors",
                 vec_index.size(), value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog sized from the number of transfers
    initial begin
        longint limit;
        wait (vectors_loaded);
        limit = (longint'(vec_index.size()) * (HALF_GAP + 30) + RESET_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("ERROR: watchdog expired after %0d ns, the DUT stopped answering", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule
